// ==== build.f ====
+incdir+include
design/gamePkg.sv
design/shipMovement.sv
design/missileMovement.sv
design/objectDrawer.sv
design/pixelArbiter.sv
design/spaceGameTop.sv
verification/spaceGame_assertions.sv
verification/spaceGameTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f build.f --top-module spaceGameTb -o spaceGameSim &&
{ ./obj_dir/spaceGameSim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "Regression passed" sim.log &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation did not pass, see sim.log"; exit 1; }

// ==== verification/spaceGameTb.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

module spaceGameTb;

    // the testbench acts as the frame source, one pulse every frameCycles clocks
    localparam int frameCycles = 20;
    localparam int clockPeriod = 8;
    localparam int holdFrames = 50;
    // crossing the whole screen from the left edge takes 76 steps
    localparam int crossFrames = 80;
    localparam int flightFrames = 112;
    localparam int randomFrames = 60;
    // reset, key tests, launch and pixel probes need a few more frames
    localparam int extraFrames = 20;
    localparam int totalFrames = holdFrames + crossFrames + flightFrames + randomFrames +
                                 extraFrames;
    localparam int timeoutNs = totalFrames * frameCycles * clockPeriod + 2000;
    localparam int maxShipX = `SCREEN_WIDTH - `SHIP_WIDTH;
    // a flying missile climbs this many pixels per frame
    localparam int missileStep = 4;

    logic           clk;
    logic           resetN;
    logic           startOfFrame;
    logic           shotKey;
    logic           leftKey;
    logic           rightKey;
    gamePkg::coordT pixelX;
    gamePkg::coordT pixelY;
    gamePkg::colorT pixelColor;
    gamePkg::coordT shipX;
    gamePkg::coordT missileX;
    gamePkg::coordT missileY;
    logic           missileActive;

    logic [31:0] lfsrState;
    // phase inside the frame of the next cycle to be driven
    int cyclePhase;

    // reference model state, it mirrors what the DUT holds after each edge
    gamePkg::coordT refShipX;
    gamePkg::fixedT refPosX;
    gamePkg::fixedT refPosY;
    logic           refPending;
    logic           refActive;
    // expected colours still travelling through the two pipeline stages
    gamePkg::colorT colorDelay [0:1];

    spaceGameTop spaceGameTop_i (
        .clk           (clk),
        .resetN        (resetN),
        .startOfFrame  (startOfFrame),
        .shotKey       (shotKey),
        .leftKey       (leftKey),
        .rightKey      (rightKey),
        .pixelX        (pixelX),
        .pixelY        (pixelY),
        .pixelColor    (pixelColor),
        .shipX         (shipX),
        .missileX      (missileX),
        .missileY      (missileY),
        .missileActive (missileActive)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clockPeriod / 2) clk = ~clk;
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkCoord(input string name, input gamePkg::coordT actual,
                              input gamePkg::coordT expected);
        if (actual !== expected) begin
            failRun($sformatf("FAIL %s: got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic checkColor(input string name, input gamePkg::colorT actual,
                              input gamePkg::colorT expected);
        if (actual !== expected) begin
            failRun($sformatf("FAIL %s: got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("FAIL %s: got %h expected %h", name, actual, expected));
        end
    endtask

    // watch the failure count of the bound checker
    always @(spaceGameTop_i.assertions_i.failures) begin
        if (spaceGameTop_i.assertions_i.failures != 0) begin
            failRun("A concurrent assertion in the bound checker failed");
        end
    end

    // one shift of a 32 bit Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // builds a value from count fresh bits, one LFSR step per bit
    function automatic int randomBits(input int count);
        int value;
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // fixed point position to whole pixels, truncated toward zero and cut to coordinate width
    function automatic gamePkg::coordT toPixel(input gamePkg::fixedT pos);
        return gamePkg::coordT'(pos / (1 << `FIXED_SHIFT));
    endfunction

    // ship column after one frame pulse with the given keys
    function automatic gamePkg::coordT nextShipX(input gamePkg::coordT x, input logic left,
                                                 input logic right);
        int target;
        target = int'(x);
        if (left && !right) begin
            target = (target < `SHIP_SPEED) ? 0 : target - `SHIP_SPEED;
        end else if (right && !left) begin
            target = (target + `SHIP_SPEED > maxShipX) ? maxShipX : target + `SHIP_SPEED;
        end
        return gamePkg::coordT'(target);
    endfunction

    // colour of one pixel: missile over ship over sky
    function automatic gamePkg::colorT expectedColor(input int px, input int py, input int shipLeft,
                                                     input int missLeft, input int missTop,
                                                     input logic missOn);
        logic inShip;
        logic inMissile;
        inShip = (px >= shipLeft) && (px < shipLeft + `SHIP_WIDTH) &&
                 (py >= `SHIP_Y) && (py < `SHIP_Y + `SHIP_HEIGHT);
        inMissile = missOn && (px >= missLeft) && (px < missLeft + `MISSILE_WIDTH) &&
                    (py >= missTop) && (py < missTop + `MISSILE_HEIGHT);
        if (inMissile) begin
            return `MISSILE_COLOR;
        end else if (inShip) begin
            return `SHIP_COLOR;
        end
        return `BACKGROUND_COLOR;
    endfunction

    // compare in mid cycle, when both the DUT outputs and the inputs are settled,
    // then step the model to what the DUT will hold after the next rising edge
    always @(negedge clk) begin
        if (!resetN) begin
            refShipX = gamePkg::coordT'(`SHIP_START_X);
            refPosX = '0;
            refPosY = '0;
            refPending = 1'b0;
            refActive = 1'b0;
            colorDelay[0] = `BACKGROUND_COLOR;
            colorDelay[1] = `BACKGROUND_COLOR;
        end else begin
            checkCoord("shipX", shipX, refShipX);
            checkCoord("missileX", missileX, toPixel(refPosX));
            checkCoord("missileY", missileY, toPixel(refPosY));
            checkFlag("missileActive", missileActive, refActive);
            checkColor("pixelColor", pixelColor, colorDelay[1]);
            colorDelay[1] = colorDelay[0];
            colorDelay[0] = expectedColor(int'(pixelX), int'(pixelY), int'(refShipX),
                                          int'(toPixel(refPosX)), int'(toPixel(refPosY)),
                                          refActive);
            if (startOfFrame) begin
                // the launch takes the ship column from before this frame's move
                if (refPending) begin
                    refPosX = int'(refShipX) * (1 << `FIXED_SHIFT);
                    refPosY = `SHIP_Y * (1 << `FIXED_SHIFT);
                    refActive = 1'b1;
                end else begin
                    refPosX = refPosX + `MISSILE_X_SPEED;
                    refPosY = refPosY + `MISSILE_Y_SPEED;
                    if (refPosY < 0) begin
                        refActive = 1'b0;
                    end
                end
                // a press on the pulse cycle itself is lost
                refPending = 1'b0;
                refShipX = nextShipX(refShipX, leftKey, rightKey);
            end else if (shotKey) begin
                refPending = 1'b1;
            end
        end
    end

    task automatic driveCycle(input logic shot, input logic left, input logic right,
                              input gamePkg::coordT px, input gamePkg::coordT py);
        @(posedge clk);
        #1;
        startOfFrame = (cyclePhase == frameCycles - 1);
        shotKey = shot;
        leftKey = left;
        rightKey = right;
        pixelX = px;
        pixelY = py;
        cyclePhase = (cyclePhase + 1) % frameCycles;
    endtask

    // random pixel, often near the ship or the missile so the drawers get hit
    task automatic randomPixelCycle(input logic shot, input logic left, input logic right);
        gamePkg::coordT px;
        gamePkg::coordT py;
        case (randomBits(2))
            1: begin
                px = gamePkg::coordT'(int'(shipX) - 8 + randomBits(6));
                py = gamePkg::coordT'(`SHIP_Y - 8 + randomBits(6));
            end
            2: begin
                px = gamePkg::coordT'(int'(missileX) - 8 + randomBits(5));
                py = gamePkg::coordT'(int'(missileY) - 8 + randomBits(5));
            end
            default: begin
                px = gamePkg::coordT'(randomBits(10));
                py = gamePkg::coordT'(randomBits(9));
            end
        endcase
        driveCycle(shot, left, right, px, py);
    endtask

    // runs through the next frame pulse and the cycle after it,
    // so the frame update is already on the outputs when this returns
    task automatic finishFrame(input logic left, input logic right);
        do begin
            randomPixelCycle(1'b0, left, right);
        end while (cyclePhase != 0);
        randomPixelCycle(1'b0, left, right);
    endtask

    // one pixel in, two idle cycles, then its colour is on the output
    task automatic probePixel(input int px, input int py, input gamePkg::colorT expected);
        driveCycle(1'b0, 1'b0, 1'b0, gamePkg::coordT'(px), gamePkg::coordT'(py));
        driveCycle(1'b0, 1'b0, 1'b0, '0, '0);
        driveCycle(1'b0, 1'b0, 1'b0, '0, '0);
        checkColor("pixelColor", pixelColor, expected);
    endtask

    initial begin : stimulus
        int frame;
        int expectedY;
        int launchX;
        resetN = 1'b0;
        startOfFrame = 1'b0;
        shotKey = 1'b0;
        leftKey = 1'b0;
        rightKey = 1'b0;
        pixelX = '0;
        pixelY = '0;
        lfsrState = 32'h2adb39c7;
        cyclePhase = 0;
        repeat (16) @(posedge clk);
        #1;
        resetN = 1'b1;
        checkCoord("shipX", shipX, gamePkg::coordT'(`SHIP_START_X));
        checkFlag("missileActive", missileActive, 1'b0);
        checkColor("pixelColor", pixelColor, `BACKGROUND_COLOR);

        // ship runs into both screen edges and stops there
        repeat (holdFrames) finishFrame(1'b1, 1'b0);
        checkCoord("shipX", shipX, '0);
        repeat (crossFrames) finishFrame(1'b0, 1'b1);
        checkCoord("shipX", shipX, gamePkg::coordT'(maxShipX));
        repeat (4) finishFrame(1'b1, 1'b0);
        launchX = maxShipX - 4 * `SHIP_SPEED;
        checkCoord("shipX", shipX, gamePkg::coordT'(launchX));
        // both keys cancel out
        repeat (2) finishFrame(1'b1, 1'b1);
        checkCoord("shipX", shipX, gamePkg::coordT'(launchX));

        // shot only on the pulse cycle is dropped
        while (cyclePhase != frameCycles - 1) randomPixelCycle(1'b0, 1'b0, 1'b0);
        randomPixelCycle(1'b1, 1'b0, 1'b0);
        randomPixelCycle(1'b0, 1'b0, 1'b0);
        checkFlag("missileActive", missileActive, 1'b0);
        finishFrame(1'b0, 1'b0);
        checkFlag("missileActive", missileActive, 1'b0);

        // shot in mid frame launches at the following pulse
        while (cyclePhase != 10) randomPixelCycle(1'b0, 1'b0, 1'b0);
        randomPixelCycle(1'b1, 1'b0, 1'b0);
        finishFrame(1'b0, 1'b0);
        checkFlag("missileActive", missileActive, 1'b1);
        checkCoord("missileX", missileX, gamePkg::coordT'(launchX));
        checkCoord("missileY", missileY, gamePkg::coordT'(`SHIP_Y));

        // missile sits on the ship's top rows right after launch, six probes fit before the pulse
        probePixel(launchX, `SHIP_Y, `MISSILE_COLOR);
        probePixel(launchX + 3, `SHIP_Y + 11, `MISSILE_COLOR);
        probePixel(launchX + 4, `SHIP_Y, `SHIP_COLOR);
        probePixel(launchX + 31, `SHIP_Y + 31, `SHIP_COLOR);
        probePixel(launchX + 32, `SHIP_Y + 10, `BACKGROUND_COLOR);
        probePixel(launchX - 1, `SHIP_Y, `BACKGROUND_COLOR);

        // flight up to and past the top edge
        for (frame = 1; frame <= flightFrames; frame++) begin
            finishFrame(1'b0, 1'b0);
            expectedY = `SHIP_Y - missileStep * frame;
            checkCoord("missileY", missileY, gamePkg::coordT'(expectedY));
            checkFlag("missileActive", missileActive, expectedY >= 0);
            if (frame == 1) begin
                // missile now pokes above the ship
                probePixel(launchX + 1, `SHIP_Y - 3, `MISSILE_COLOR);
                probePixel(launchX + 1, `SHIP_Y + 8, `SHIP_COLOR);
            end
        end

        // long random run, the comparing process checks every cycle
        repeat (randomFrames * frameCycles) begin
            randomPixelCycle(randomBits(3) == 7, randomBits(1) == 1, randomBits(1) == 1);
        end
        repeat (3) randomPixelCycle(1'b0, 1'b0, 1'b0);

        $display("Regression passed");
        $finish;
    end

    // bound on the run length taken from the frame budget above
    initial begin
        #(timeoutNs);
        failRun("Timeout, the tests did not finish within the expected number of frames");
    end

endmodule

// ==== verification/spaceGame_assertions.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// protocol checks that sit inside the DUT through bind
module spaceGame_assertions (
    input logic           clk,
    input logic           resetN,
    input logic           startOfFrame,
    input gamePkg::coordT shipX,
    input logic           missileActive,
    input gamePkg::colorT pixelColor
);

    // count of failed assertions, watched by the testbench
    int failures = 0;

    // the whole ship stays on the screen in every cycle
    shipOnScreen: assert property (@(posedge clk) disable iff (!resetN)
        (int'(shipX) >= 0) && (int'(shipX) <= `SCREEN_WIDTH - `SHIP_WIDTH))
    else begin
        failures++;
        $error("shipX %0d is outside the screen", shipX);
    end

    // a launch is only taken at the frame pulse, so the flag rises one cycle later
    launchOnFrame: assert property (@(posedge clk) disable iff (!resetN)
        $rose(missileActive) |-> $past(startOfFrame))
    else begin
        failures++;
        $error("missileActive rose without a frame pulse in the cycle before");
    end

    // screen stays blank while reset is held
    blankInReset: assert property (@(posedge clk)
        !resetN |-> (pixelColor == `BACKGROUND_COLOR))
    else begin
        failures++;
        $error("pixelColor %h is not the background during reset", pixelColor);
    end

endmodule

bind spaceGameTop spaceGame_assertions assertions_i (
    .clk           (clk),
    .resetN        (resetN),
    .startOfFrame  (startOfFrame),
    .shipX         (shipX),
    .missileActive (missileActive),
    .pixelColor    (pixelColor)
);

// ==== design/spaceGameTop.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// object layer of the shooter
// pixel coordinates come from an external timing generator,
// the colour comes out two cycles later
module spaceGameTop (
    input  logic           clk,
    input  logic           resetN,
    input  logic           startOfFrame,
    input  logic           shotKey,
    input  logic           leftKey,
    input  logic           rightKey,
    input  gamePkg::coordT pixelX,
    input  gamePkg::coordT pixelY,
    output gamePkg::colorT pixelColor,
    output gamePkg::coordT shipX,
    output gamePkg::coordT missileX,
    output gamePkg::coordT missileY,
    output logic           missileActive
);

    // requests and colours from the drawers to the arbiter
    logic           shipRequest;
    logic           missileRequest;
    gamePkg::colorT shipColor;
    gamePkg::colorT missileColor;

    // ship column, updated once per frame
    shipMovement shipMovement_i (
        .clk          (clk),
        .resetN       (resetN),
        .startOfFrame (startOfFrame),
        .leftKey      (leftKey),
        .rightKey     (rightKey),
        .shipX        (shipX)
    );

    // the missile launches from wherever the ship is at the frame pulse
    missileMovement missileMovement_i (
        .clk           (clk),
        .resetN        (resetN),
        .startOfFrame  (startOfFrame),
        .shotKey       (shotKey),
        .shipX         (shipX),
        .missileX      (missileX),
        .missileY      (missileY),
        .missileActive (missileActive)
    );

    // ship sits on a fixed row and is always shown
    objectDrawer #(
        .objWidth  (`SHIP_WIDTH),
        .objHeight (`SHIP_HEIGHT),
        .objColor  (`SHIP_COLOR)
    ) shipDrawer_i (
        .clk         (clk),
        .resetN      (resetN),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .topLeftX    (shipX),
        .topLeftY    (gamePkg::coordT'(`SHIP_Y)),
        .visible     (1'b1),
        .drawRequest (shipRequest),
        .objectColor (shipColor)
    );

    // missile is only drawn while it is in flight
    objectDrawer #(
        .objWidth  (`MISSILE_WIDTH),
        .objHeight (`MISSILE_HEIGHT),
        .objColor  (`MISSILE_COLOR)
    ) missileDrawer_i (
        .clk         (clk),
        .resetN      (resetN),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .topLeftX    (missileX),
        .topLeftY    (missileY),
        .visible     (missileActive),
        .drawRequest (missileRequest),
        .objectColor (missileColor)
    );

    // final colour selection
    pixelArbiter pixelArbiter_i (
        .clk            (clk),
        .resetN         (resetN),
        .missileRequest (missileRequest),
        .shipRequest    (shipRequest),
        .missileColor   (missileColor),
        .shipColor      (shipColor),
        .pixelColor     (pixelColor)
    );

endmodule

// ==== design/pixelArbiter.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// shares the one pixel colour output between the drawers
// priority is fixed, missile on top, then ship, then the sky
module pixelArbiter (
    input  logic           clk,
    input  logic           resetN,
    input  logic           missileRequest,
    input  logic           shipRequest,
    input  gamePkg::colorT missileColor,
    input  gamePkg::colorT shipColor,
    // colour sent to the video output
    output gamePkg::colorT pixelColor
);

    // colour of the winning requester for this pixel
    gamePkg::colorT grantColor;

    // the missile is drawn over the ship when the two overlap,
    // which happens right after a launch
    always_comb begin
        if (missileRequest) begin
            grantColor = missileColor;
        end else if (shipRequest) begin
            grantColor = shipColor;
        end else begin
            // nobody claims the pixel
            grantColor = `BACKGROUND_COLOR;
        end
    end

    // output register, second stage of the pixel pipeline
    // held at the sky colour while in reset so the screen stays blank
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixelColor <= `BACKGROUND_COLOR;
        end else begin
            pixelColor <= grantColor;
        end
    end

endmodule

// ==== design/objectDrawer.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// solid rectangle drawer
// one instance per object, each one competes for the pixel through the arbiter
module objectDrawer #(
    parameter int             objWidth  = `SHIP_WIDTH,
    parameter int             objHeight = `SHIP_HEIGHT,
    parameter gamePkg::colorT objColor  = `SHIP_COLOR
) (
    input  logic           clk,
    input  logic           resetN,
    // pixel currently being scanned
    input  gamePkg::coordT pixelX,
    input  gamePkg::coordT pixelY,
    // object corner, may be negative when the object is clipped
    input  gamePkg::coordT topLeftX,
    input  gamePkg::coordT topLeftY,
    input  logic           visible,
    output logic           drawRequest,
    output gamePkg::colorT objectColor
);

    // edges just past the object, the rectangle is half open
    int rightEdge;
    int bottomEdge;
    logic insideX;
    logic insideY;
    logic hit;

    // everything is widened to signed int so negative corners compare correctly
    assign rightEdge  = int'(topLeftX) + objWidth;
    assign bottomEdge = int'(topLeftY) + objHeight;

    assign insideX = (int'(pixelX) >= int'(topLeftX)) && (int'(pixelX) < rightEdge);
    assign insideY = (int'(pixelY) >= int'(topLeftY)) && (int'(pixelY) < bottomEdge);

    // a hidden object never asks for the pixel
    assign hit = visible && insideX && insideY;

    // request is registered, one cycle behind the pixel coordinate
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            drawRequest <= 1'b0;
        end else begin
            drawRequest <= hit;
        end
    end

    // colour travels alongside the request
    // when not hit it shows the sky, the arbiter ignores it anyway
    always_ff @(posedge clk) begin
        if (hit) begin
            objectColor <= objColor;
        end else begin
            objectColor <= `BACKGROUND_COLOR;
        end
    end

endmodule

// ==== design/missileMovement.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// single missile, launched from the ship and flying up the screen
module missileMovement (
    input  logic           clk,
    input  logic           resetN,
    input  logic           startOfFrame,
    // shot request, may be a single cycle anywhere in the frame
    input  logic           shotKey,
    input  gamePkg::coordT shipX,
    // top left corner of the missile in whole pixels
    output gamePkg::coordT missileX,
    output gamePkg::coordT missileY,
    output logic           missileActive
);

    // one pixel expressed in fixed point units
    localparam gamePkg::fixedT fixedOne = 1 << `FIXED_SHIFT;

    // a shot seen during the frame, acted on at the next frame pulse
    logic shotPending;
    // position in 1/64 pixel
    gamePkg::fixedT posX;
    gamePkg::fixedT posY;
    // position after one more frame of flight
    gamePkg::fixedT stepX;
    gamePkg::fixedT stepY;

    assign stepX = posX + gamePkg::fixedT'(`MISSILE_X_SPEED);
    assign stepY = posY + gamePkg::fixedT'(`MISSILE_Y_SPEED);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posX          <= '0;
            posY          <= '0;
            shotPending   <= 1'b0;
            missileActive <= 1'b0;
        end else begin
            // remember the shot until the frame pulse
            if (shotKey) begin
                shotPending <= 1'b1;
            end
            // the frame assignments come last and win over the latch above,
            // so a press on the pulse cycle itself is dropped
            if (startOfFrame) begin
                shotPending <= 1'b0;
                if (shotPending) begin
                    // launch from the ship's nose position
                    posX          <= gamePkg::fixedT'(shipX) * fixedOne;
                    posY          <= gamePkg::fixedT'(`SHIP_Y) * fixedOne;
                    missileActive <= 1'b1;
                end else begin
                    posX <= stepX;
                    posY <= stepY;
                    // gone once it crosses the top edge
                    if (stepY < 0) begin
                        missileActive <= 1'b0;
                    end
                end
            end
        end
    end

    // back to whole pixels, signed division rounds toward zero
    assign missileX = gamePkg::coordT'(posX / fixedOne);
    assign missileY = gamePkg::coordT'(posY / fixedOne);

endmodule

// ==== design/shipMovement.sv ====
`timescale 1ns/1ps
`include "game_cfg.svh"

// the player ship only moves sideways, its row is fixed by SHIP_Y
module shipMovement (
    input  logic           clk,
    input  logic           resetN,
    // one cycle pulse at the start of every frame
    input  logic           startOfFrame,
    input  logic           leftKey,
    input  logic           rightKey,
    // left edge of the ship
    output gamePkg::coordT shipX
);

    // rightmost legal left edge, so the whole ship stays on screen
    localparam int maxX = `SCREEN_WIDTH - `SHIP_WIDTH;

    // candidate positions are computed as int so the clamp sees the true value
    int movedLeft;
    int movedRight;
    gamePkg::coordT nextX;

    assign movedLeft  = int'(shipX) - `SHIP_SPEED;
    assign movedRight = int'(shipX) + `SHIP_SPEED;

    // pick the next column from the keys
    // both keys together cancel out and the ship stays where it is
    always_comb begin
        nextX = shipX;
        if (leftKey && !rightKey) begin
            if (movedLeft < 0) begin
                nextX = '0;
            end else begin
                nextX = gamePkg::coordT'(movedLeft);
            end
        end else if (rightKey && !leftKey) begin
            // clamp at the right border, a step may overshoot it
            if (movedRight > maxX) begin
                nextX = gamePkg::coordT'(maxX);
            end else begin
                nextX = gamePkg::coordT'(movedRight);
            end
        end
    end

    // the column only changes on the frame pulse
    // so the ship moves at most one step per frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            // ship starts centred at the bottom of the screen
            shipX <= gamePkg::coordT'(`SHIP_START_X);
        end else if (startOfFrame) begin
            shipX <= nextX;
        end
    end

endmodule

// ==== design/gamePkg.sv ====
`include "game_cfg.svh"

package gamePkg;

    // signed pixel coordinate
    // an object that is partly above or left of the screen has a negative corner
    typedef logic signed [`PIXEL_WIDTH-1:0] coordT;

    // signed position in 1/64 pixel
    // the low FIXED_SHIFT bits are the fraction, so slow speeds still accumulate
    // over several frames instead of being lost to rounding
    typedef logic signed [31:0] fixedT;

    // RGB332 colour, three bits red, three bits green, two bits blue
    typedef logic [7:0] colorT;

endpackage

// ==== include/game_cfg.svh ====
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// width of a signed pixel coordinate, wide enough for 640x480 plus a sign
`define PIXEL_WIDTH 11
// positions are kept in 1/64 pixel, so the shift is log2 of 64
`define FIXED_SHIFT 6

// visible screen area in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// player ship geometry and motion
`define SHIP_WIDTH 32
`define SHIP_HEIGHT 32
`define SHIP_Y 440
`define SHIP_START_X 304
`define SHIP_SPEED 8

// missile geometry and speeds, the speeds are in 1/64 pixel per frame
`define MISSILE_WIDTH 4
`define MISSILE_HEIGHT 12
`define MISSILE_X_SPEED 0
`define MISSILE_Y_SPEED (-256)

// RGB332 colours of the objects and of the empty sky
`define SHIP_COLOR 8'h1C
`define MISSILE_COLOR 8'hE0
`define BACKGROUND_COLOR 8'h00

`endif
